// File: tb.f
rtl/eth_noc_pkg.sv
rtl/flit_fifo.sv
rtl/special_flit_detect.sv
rtl/eth_regfile.sv
rtl/eth_noc_bridge.sv
tb/eth_noc_bridge_sva.sv
tb/tb_eth_noc_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the bridge testbench with verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eth_noc_bridge -f tb.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_eth_noc_bridge +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb/tb_eth_noc_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eth_noc_bridge
    import eth_noc_pkg::*;
();

    localparam int N_FLITS = 120;  // per direction
    localparam int WATCHDOG_CYCLES = (2 * N_FLITS + 4) * 40 + 2000;
    localparam logic [CHIPID_W-1:0] HOME_CHIPID = 8'h05;
    localparam logic [CHIPID_W-1:0] NEW_CHIPID  = 8'h2a;

    logic                  clk_eth_i = 1'b0;
    logic                  reset_i;
    logic                  udp_rx_valid_i;
    logic                  udp_rx_ready_o;
    flit_t                 udp_rx_flit_i;
    logic [31:0]           udp_rx_src_ip_i;
    logic                  noc_tx_valid_o;
    logic                  noc_tx_ready_i;
    flit_t                 noc_tx_flit_o;
    logic                  noc_rx_valid_i;
    logic                  noc_rx_ready_o;
    flit_t                 noc_rx_flit_i;
    logic                  udp_tx_valid_o;
    logic                  udp_tx_ready_i;
    flit_t                 udp_tx_flit_o;
    logic [31:0]           udp_dst_ip_o;
    logic [15:0]           udp_dst_port_o;
    logic [15:0]           udp_src_port_o;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    logic [APB_ADDR_W-1:0] paddr_i;
    logic [31:0]           pwdata_i;
    logic [31:0]           prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;
    logic [CHIPID_W-1:0]   home_chipid_i;
    logic [CHIPID_W-1:0]   host_chipid_o;
    logic                  eth_system_reset_o;

    flit_t       ingress_q[$];
    flit_t       egress_q[$];
    flit_t       exp_flit;
    flit_t       special;
    int          error_count   = 0;
    int          ingress_count = 0;
    int          egress_count  = 0;
    int unsigned sva_errors;
    logic [31:0] lfsr_state = 32'he0d2;
    logic [31:0] rdata;
    logic        rerr;

    always #5 clk_eth_i = ~clk_eth_i;

    eth_noc_bridge dut_i (.*);

    task automatic report_mismatch(input string what);
        $display("FAILED at %0d ns: %s", $time, what);
        error_count++;
    endtask

    task automatic report_problem(input string what);
        $display("error: %s", what);
        error_count++;
    endtask

    // taps 32 22 2 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic flit_t random_flit();
        flit_t f;
        f.burst      = 1'(rand_bits(1));
        f.mode       = MODE_W'(rand_bits(MODE_W));
        f.trg_chipid = CHIPID_W'(rand_bits(CHIPID_W));
        f.trg_modid  = MODID_W'(rand_bits(MODID_W));
        f.src_chipid = CHIPID_W'(rand_bits(CHIPID_W));
        f.src_modid  = MODID_W'(rand_bits(MODID_W));
        f.addr       = ADDR_W'(rand_bits(ADDR_W));
        f.data0      = rand_bits(DATA_W);
        f.data1      = rand_bits(DATA_W);
        return f;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] data,
                            output logic err);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk_eth_i);
        #1;
        penable_i = 1'b1;
        @(negedge clk_eth_i);
        data = prdata_o;
        err  = pslverr_o;
        @(posedge clk_eth_i);  // access edge
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic check_read(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_xfer(1'b0, addr, '0, data, err);
        assert (data == exp && !err)
            else report_mismatch($sformatf("read 0x%02h gave %h slverr %b, expected %h",
                                           addr, data, err, exp));
    endtask

    task automatic send_ingress(input flit_t f, input logic [31:0] ip);
        logic done;
        done            = 1'b0;
        udp_rx_flit_i   = f;
        udp_rx_src_ip_i = ip;
        udp_rx_valid_i  = 1'b1;
        while (!done) begin
            @(negedge clk_eth_i);
            done = udp_rx_ready_o;
            @(posedge clk_eth_i);
            #1;
        end
        udp_rx_valid_i = 1'b0;
    endtask

    // first negedge after the trigger edge is pulse cycle 0
    task automatic check_pulse(input logic expect_pulse, input string what);
        for (int i = 0; i <= SYS_RESET_CYCLES; i++) begin
            @(negedge clk_eth_i);
            assert (eth_system_reset_o == (expect_pulse && i < SYS_RESET_CYCLES))
                else report_mismatch($sformatf("%s: eth_system_reset_o %b in cycle %0d",
                                               what, eth_system_reset_o, i));
        end
        @(posedge clk_eth_i);
        #1;
    endtask

    task automatic run_traffic(input int n);
        int   in_sent;
        int   eg_sent;
        logic in_hs;
        logic eg_hs;
        in_sent = 0;
        eg_sent = 0;
        while (in_sent < n || eg_sent < n || ingress_q.size() != 0 || egress_q.size() != 0) begin
            noc_tx_ready_i = (rand_bits(2) != 0);
            udp_tx_ready_i = (rand_bits(2) != 0);
            if (!udp_rx_valid_i && in_sent < n && rand_bits(1) != 0) begin
                udp_rx_flit_i   = random_flit();
                udp_rx_src_ip_i = 32'(rand_bits(32));
                udp_rx_valid_i  = 1'b1;
            end
            if (!noc_rx_valid_i && eg_sent < n && rand_bits(1) != 0) begin
                noc_rx_flit_i  = random_flit();
                noc_rx_valid_i = 1'b1;
            end
            @(negedge clk_eth_i);
            in_hs = udp_rx_valid_i && udp_rx_ready_o;
            eg_hs = noc_rx_valid_i && noc_rx_ready_o;
            @(posedge clk_eth_i);
            #1;
            if (in_hs) begin
                udp_rx_valid_i = 1'b0;
                in_sent++;
            end
            if (eg_hs) begin
                noc_rx_valid_i = 1'b0;
                eg_sent++;
            end
        end
        noc_tx_ready_i = 1'b1;
        udp_tx_ready_i = 1'b1;
    endtask

    // reference queues, sampled mid cycle
    always @(negedge clk_eth_i) begin
        if (!reset_i) begin
            if (noc_tx_valid_o && noc_tx_ready_i) begin
                assert (ingress_q.size() != 0)
                    else report_problem("flit left on the NoC side with none outstanding");
                if (ingress_q.size() != 0) begin
                    exp_flit = ingress_q.pop_front();
                    assert (noc_tx_flit_o == exp_flit)
                        else report_mismatch($sformatf("noc_tx flit %h, expected %h",
                                                       noc_tx_flit_o, exp_flit));
                end
            end
            if (udp_tx_valid_o && udp_tx_ready_i) begin
                assert (egress_q.size() != 0)
                    else report_problem("flit left on the UDP side with none outstanding");
                if (egress_q.size() != 0) begin
                    exp_flit = egress_q.pop_front();
                    assert (udp_tx_flit_o == exp_flit)
                        else report_mismatch($sformatf("udp_tx flit %h, expected %h",
                                                       udp_tx_flit_o, exp_flit));
                end
            end
            if (udp_rx_valid_i && udp_rx_ready_o) begin
                ingress_q.push_back(udp_rx_flit_i);
                ingress_count++;
            end
            if (noc_rx_valid_i && noc_rx_ready_o) begin
                egress_q.push_back(noc_rx_flit_i);
                egress_count++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_eth_i);
        $display("error: watchdog expired after %0d cycles, the test did not finish",
                 WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        reset_i         = 1'b1;
        udp_rx_valid_i  = 1'b0;
        udp_rx_flit_i   = '0;
        udp_rx_src_ip_i = '0;
        noc_tx_ready_i  = 1'b1;
        noc_rx_valid_i  = 1'b0;
        noc_rx_flit_i   = '0;
        udp_tx_ready_i  = 1'b1;
        psel_i          = 1'b0;
        penable_i       = 1'b0;
        pwrite_i        = 1'b0;
        paddr_i         = '0;
        pwdata_i        = '0;
        home_chipid_i   = HOME_CHIPID;
        repeat (8) @(posedge clk_eth_i);
        #1;
        reset_i = 1'b0;
        assert (udp_rx_ready_o && noc_rx_ready_o)
            else report_problem("a FIFO is not ready after reset");

        check_read(REG_HOST_IP, {8'd192, 8'd168, 8'd42, 8'd25});
        check_read(REG_HOST_PORT, 32'd1800);
        check_read(REG_FPGA_PORT, 32'd1800);
        check_read(REG_HOST_CHIPID, 32'd0);
        apb_xfer(1'b1, REG_HOST_IP, 32'h0a0b0c0d, rdata, rerr);
        apb_xfer(1'b1, REG_HOST_PORT, 32'h00001234, rdata, rerr);
        apb_xfer(1'b1, REG_FPGA_PORT, 32'h00004321, rdata, rerr);
        apb_xfer(1'b1, REG_HOST_CHIPID, 32'(NEW_CHIPID), rdata, rerr);
        check_read(REG_HOST_IP, 32'h0a0b0c0d);
        check_read(REG_HOST_PORT, 32'h00001234);
        check_read(REG_FPGA_PORT, 32'h00004321);
        check_read(REG_HOST_CHIPID, 32'(NEW_CHIPID));
        assert (udp_dst_ip_o == 32'h0a0b0c0d && udp_dst_port_o == 16'h1234 &&
                udp_src_port_o == 16'h4321 && host_chipid_o == NEW_CHIPID)
            else report_mismatch("register outputs do not follow the APB writes");
        apb_xfer(1'b0, 8'h20, '0, rdata, rerr);
        assert (rerr) else report_problem("no slave error on unmapped offset 0x20");

        run_traffic(N_FLITS);

        special            = random_flit();
        special.burst      = 1'b0;
        special.mode       = MODE_WRITE_POSTED;
        special.trg_chipid = HOME_CHIPID;
        special.trg_modid  = HOME_MODID;
        special.addr       = RESET_ADDR;
        special.data0      = 64'd1;
        send_ingress(special, 32'h0a000001);
        check_pulse(1'b1, "reset flit");
        special.data0 = 64'd2;
        send_ingress(special, 32'h0a000001);
        check_pulse(1'b0, "reset flit with data 2");
        apb_xfer(1'b1, REG_SYS_RESET, 32'd1, rdata, rerr);
        check_pulse(1'b1, "reset register write");

        // host self test flit
        special.src_modid  = MODID_ETH;
        special.src_chipid = NEW_CHIPID;
        special.trg_chipid = NEW_CHIPID;
        special.addr       = HOST_IP_MAGIC_ADDR;
        special.data0      = HOST_IP_MAGIC_DATA;
        send_ingress(special, 32'h0a000102);
        @(negedge clk_eth_i);
        assert (udp_dst_ip_o == 32'h0a000102)
            else report_mismatch($sformatf("udp_dst_ip_o %h after magic flit", udp_dst_ip_o));
        @(posedge clk_eth_i);
        #1;
        check_read(REG_HOST_IP, 32'h0a000102);
        special.src_modid = 8'h3e;
        send_ingress(special, 32'h0a000199);
        @(negedge clk_eth_i);
        assert (udp_dst_ip_o == 32'h0a000102)
            else report_mismatch($sformatf("udp_dst_ip_o %h after bad magic flit", udp_dst_ip_o));
        @(posedge clk_eth_i);
        #1;

        check_read(REG_STATUS, {egress_count[15:0], ingress_count[15:0]});
        assert (ingress_q.size() == 0 && egress_q.size() == 0)
            else report_problem("flits still outstanding at the end of the run");

        sva_errors = dut_i.sva_i.fail_count;
        $display("errors: %0d in testbench checks, %0d in bound assertions",
                 error_count, sva_errors);
        if (error_count == 0 && sva_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/eth_noc_bridge_sva.sv
`timescale 1ns/1ps
`default_nettype none

module eth_noc_bridge_sva
    import eth_noc_pkg::*;
(
    input wire   clk_eth_i,
    input wire   reset_i,
    input wire   noc_tx_valid_i,
    input wire   noc_tx_ready_i,
    input flit_t noc_tx_flit_i,
    input wire   udp_tx_valid_i,
    input wire   udp_tx_ready_i,
    input flit_t udp_tx_flit_i,
    input wire   sys_reset_i,
    input wire   psel_i,
    input wire   penable_i,
    input wire   pready_i
);

    int unsigned fail_count = 0;

    noc_tx_hold: assert property (@(posedge clk_eth_i) disable iff (reset_i)
        noc_tx_valid_i && !noc_tx_ready_i |=> noc_tx_valid_i && $stable(noc_tx_flit_i))
        else begin
            $error("noc_tx valid dropped or flit changed while stalled");
            fail_count++;
        end

    udp_tx_hold: assert property (@(posedge clk_eth_i) disable iff (reset_i)
        udp_tx_valid_i && !udp_tx_ready_i |=> udp_tx_valid_i && $stable(udp_tx_flit_i))
        else begin
            $error("udp_tx valid dropped or flit changed while stalled");
            fail_count++;
        end

    // covers every reset cycle after the first edge, and the one after
    quiet_after_reset: assert property (@(posedge clk_eth_i)
        reset_i |=> !noc_tx_valid_i && !udp_tx_valid_i && !sys_reset_i)
        else begin
            $error("output valid or system reset high during or right after reset");
            fail_count++;
        end

    apb_no_wait: assert property (@(posedge clk_eth_i) disable iff (reset_i)
        psel_i && penable_i |-> pready_i)
        else begin
            $error("pready low in an APB access cycle");
            fail_count++;
        end

endmodule

bind eth_noc_bridge eth_noc_bridge_sva sva_i (
    .clk_eth_i      (clk_eth_i),
    .reset_i        (reset_i),
    .noc_tx_valid_i (noc_tx_valid_o),
    .noc_tx_ready_i (noc_tx_ready_i),
    .noc_tx_flit_i  (noc_tx_flit_o),
    .udp_tx_valid_i (udp_tx_valid_o),
    .udp_tx_ready_i (udp_tx_ready_i),
    .udp_tx_flit_i  (udp_tx_flit_o),
    .sys_reset_i    (eth_system_reset_o),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pready_i       (pready_o)
);

`default_nettype wire

// File: rtl/eth_noc_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module eth_noc_bridge
    import eth_noc_pkg::*;
(
    input  wire                  clk_eth_i,
    input  wire                  reset_i,

    input  wire                  udp_rx_valid_i,
    output logic                 udp_rx_ready_o,
    input  flit_t                udp_rx_flit_i,
    input  wire [31:0]           udp_rx_src_ip_i,

    output logic                 noc_tx_valid_o,
    input  wire                  noc_tx_ready_i,
    output flit_t                noc_tx_flit_o,

    input  wire                  noc_rx_valid_i,
    output logic                 noc_rx_ready_o,
    input  flit_t                noc_rx_flit_i,

    output logic                 udp_tx_valid_o,
    input  wire                  udp_tx_ready_i,
    output flit_t                udp_tx_flit_o,
    output logic [31:0]          udp_dst_ip_o,
    output logic [15:0]          udp_dst_port_o,
    output logic [15:0]          udp_src_port_o,

    input  wire                  psel_i,
    input  wire                  penable_i,
    input  wire                  pwrite_i,
    input  wire [APB_ADDR_W-1:0] paddr_i,
    input  wire [31:0]           pwdata_i,
    output logic [31:0]          prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,

    input  wire [CHIPID_W-1:0]   home_chipid_i,
    output logic [CHIPID_W-1:0]  host_chipid_o,
    output logic                 eth_system_reset_o
);

    ingress_item_t ingress_in;
    ingress_item_t ingress_out;
    logic          ingress_fire;
    logic          egress_fire;
    logic          sys_reset_hit;
    logic          host_ip_hit;

    assign ingress_in   = '{flit: udp_rx_flit_i, src_ip: udp_rx_src_ip_i};
    assign noc_tx_flit_o = ingress_out.flit;

    // both paths counted on the write side
    assign ingress_fire = udp_rx_valid_i && udp_rx_ready_o;
    assign egress_fire  = noc_rx_valid_i && noc_rx_ready_o;

    flit_fifo #(.payload_t(ingress_item_t)) ingress_fifo_i (
        .clk_eth_i   (clk_eth_i),
        .reset_i     (reset_i),
        .in_valid_i  (udp_rx_valid_i),
        .in_ready_o  (udp_rx_ready_o),
        .in_data_i   (ingress_in),
        .out_valid_o (noc_tx_valid_o),
        .out_ready_i (noc_tx_ready_i),
        .out_data_o  (ingress_out)
    );

    flit_fifo #(.payload_t(flit_t)) egress_fifo_i (
        .clk_eth_i   (clk_eth_i),
        .reset_i     (reset_i),
        .in_valid_i  (noc_rx_valid_i),
        .in_ready_o  (noc_rx_ready_o),
        .in_data_i   (noc_rx_flit_i),
        .out_valid_o (udp_tx_valid_o),
        .out_ready_i (udp_tx_ready_i),
        .out_data_o  (udp_tx_flit_o)
    );

    special_flit_detect special_flit_detect_i (
        .fire_i          (ingress_fire),
        .flit_i          (udp_rx_flit_i),
        .home_chipid_i   (home_chipid_i),
        .host_chipid_i   (host_chipid_o),
        .sys_reset_hit_o (sys_reset_hit),
        .host_ip_hit_o   (host_ip_hit)
    );

    eth_regfile eth_regfile_i (
        .clk_eth_i          (clk_eth_i),
        .reset_i            (reset_i),
        .psel_i             (psel_i),
        .penable_i          (penable_i),
        .pwrite_i           (pwrite_i),
        .paddr_i            (paddr_i),
        .pwdata_i           (pwdata_i),
        .prdata_o           (prdata_o),
        .pready_o           (pready_o),
        .pslverr_o          (pslverr_o),
        .sys_reset_hit_i    (sys_reset_hit),
        .host_ip_hit_i      (host_ip_hit),
        .src_ip_i           (udp_rx_src_ip_i),
        .ingress_fire_i     (ingress_fire),
        .egress_fire_i      (egress_fire),
        .host_ip_o          (udp_dst_ip_o),   // udp destination is the host
        .host_port_o        (udp_dst_port_o),
        .fpga_port_o        (udp_src_port_o),
        .host_chipid_o      (host_chipid_o),
        .eth_system_reset_o (eth_system_reset_o)
    );

endmodule

`default_nettype wire

// File: rtl/eth_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module eth_regfile
    import eth_noc_pkg::*;
(
    input  wire                  clk_eth_i,
    input  wire                  reset_i,

    input  wire                  psel_i,
    input  wire                  penable_i,
    input  wire                  pwrite_i,
    input  wire [APB_ADDR_W-1:0] paddr_i,
    input  wire [31:0]           pwdata_i,
    output logic [31:0]          prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,

    input  wire                  sys_reset_hit_i,
    input  wire                  host_ip_hit_i,
    input  wire [31:0]           src_ip_i,
    input  wire                  ingress_fire_i,
    input  wire                  egress_fire_i,

    output logic [31:0]          host_ip_o,
    output logic [15:0]          host_port_o,
    output logic [15:0]          fpga_port_o,
    output logic [CHIPID_W-1:0]  host_chipid_o,
    output logic                 eth_system_reset_o
);

    localparam int CNT_W = $clog2(SYS_RESET_CYCLES + 1);

    logic             apb_access;
    logic             apb_wr;
    logic             addr_hit;
    logic             trigger_reset;
    logic [CNT_W-1:0] reset_cnt;
    logic [15:0]      ingress_cnt;
    logic [15:0]      egress_cnt;

    assign apb_access = psel_i && penable_i;
    assign apb_wr     = apb_access && pwrite_i;
    assign pready_o   = 1'b1;  // no wait states

    always_ff @(posedge clk_eth_i) begin
        if (reset_i) begin
            host_ip_o     <= HOST_IP_RESET;
            host_port_o   <= HOST_PORT_RESET;
            fpga_port_o   <= FPGA_PORT_RESET;
            host_chipid_o <= HOST_CHIPID_RESET;
        end else begin
            if (host_ip_hit_i) begin
                host_ip_o <= src_ip_i;  // learned ip beats apb
            end else if (apb_wr && paddr_i == REG_HOST_IP) begin
                host_ip_o <= pwdata_i;
            end
            if (apb_wr && paddr_i == REG_HOST_PORT) begin
                host_port_o <= pwdata_i[15:0];
            end
            if (apb_wr && paddr_i == REG_FPGA_PORT) begin
                fpga_port_o <= pwdata_i[15:0];
            end
            if (apb_wr && paddr_i == REG_HOST_CHIPID) begin
                host_chipid_o <= pwdata_i[CHIPID_W-1:0];
            end
        end
    end

    assign trigger_reset = sys_reset_hit_i ||
                           (apb_wr && paddr_i == REG_SYS_RESET && pwdata_i[0]);

    // pulse length set by the down counter
    always_ff @(posedge clk_eth_i) begin
        if (reset_i) begin
            reset_cnt <= '0;
        end else if (trigger_reset) begin
            reset_cnt <= CNT_W'(SYS_RESET_CYCLES);
        end else if (reset_cnt != '0) begin
            reset_cnt <= reset_cnt - 1'b1;
        end
    end

    assign eth_system_reset_o = (reset_cnt != '0);

    always_ff @(posedge clk_eth_i) begin
        if (reset_i) begin
            ingress_cnt <= '0;
            egress_cnt  <= '0;
        end else begin
            if (ingress_fire_i) ingress_cnt <= ingress_cnt + 1'b1;  // wraps
            if (egress_fire_i)  egress_cnt  <= egress_cnt + 1'b1;
        end
    end

    always_comb begin
        prdata_o = '0;
        addr_hit = 1'b1;
        case (paddr_i)
            REG_HOST_IP:     prdata_o = host_ip_o;
            REG_HOST_PORT:   prdata_o = {16'h0, host_port_o};
            REG_FPGA_PORT:   prdata_o = {16'h0, fpga_port_o};
            REG_HOST_CHIPID: prdata_o = 32'(host_chipid_o);
            REG_SYS_RESET:   prdata_o = '0;
            REG_STATUS:      prdata_o = {egress_cnt, ingress_cnt};
            default:         addr_hit = 1'b0;
        endcase
    end

    assign pslverr_o = apb_access && !addr_hit;

endmodule

`default_nettype wire

// File: rtl/special_flit_detect.sv
`timescale 1ns/1ps
`default_nettype none

module special_flit_detect
    import eth_noc_pkg::*;
(
    input  wire                fire_i,  // ingress write handshake
    input  flit_t              flit_i,
    input  wire [CHIPID_W-1:0] home_chipid_i,
    input  wire [CHIPID_W-1:0] host_chipid_i,
    output logic               sys_reset_hit_o,
    output logic               host_ip_hit_o
);

    logic posted_to_home;
    logic reset_match;
    logic host_ip_match;

    // single posted write aimed at our own module
    assign posted_to_home = !flit_i.burst &&
                            (flit_i.trg_modid == HOME_MODID) &&
                            (flit_i.mode == MODE_WRITE_POSTED);

    always_comb begin
        reset_match = posted_to_home &&
                      (flit_i.trg_chipid == home_chipid_i) &&
                      (flit_i.addr == RESET_ADDR) &&
                      (flit_i.data0 == DATA_W'(1));
    end

    // magic flit from the host self test
    always_comb begin
        host_ip_match = posted_to_home &&
                        (flit_i.src_modid == MODID_ETH) &&
                        (flit_i.src_chipid == host_chipid_i) &&
                        (flit_i.trg_chipid == host_chipid_i) &&
                        (flit_i.addr == HOST_IP_MAGIC_ADDR) &&
                        (flit_i.data0 == HOST_IP_MAGIC_DATA);
    end

    always_comb begin
        sys_reset_hit_o = 1'b0;
        host_ip_hit_o   = 1'b0;
        if (fire_i) begin
            if (reset_match) begin
                sys_reset_hit_o = 1'b1;
            end else if (host_ip_match) begin
                host_ip_hit_o = 1'b1;  // reset wins when both match
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/flit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// DEPTH must be a power of two, 2 or more
module flit_fifo
    import eth_noc_pkg::*;
#(
    parameter type payload_t = flit_t,
    parameter int  DEPTH     = FIFO_DEPTH
) (
    input  wire      clk_eth_i,
    input  wire      reset_i,

    input  wire      in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  wire      out_ready_i,
    output payload_t out_data_o
);

    localparam int AW = $clog2(DEPTH);

    payload_t mem [DEPTH];

    // extra msb tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        push;
    logic        pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign in_ready_o  = !full;
    assign out_valid_o = !empty;
    assign out_data_o  = mem[rd_ptr[AW-1:0]];

    assign push = in_valid_i && !full;
    assign pop  = out_ready_i && !empty;

    always_ff @(posedge clk_eth_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_eth_i) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= in_data_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/eth_noc_pkg.sv
`default_nettype none

package eth_noc_pkg;

    localparam int CHIPID_W   = 8;
    localparam int MODID_W    = 8;
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int MODE_W     = 4;
    localparam int APB_ADDR_W = 8;
    localparam int FIFO_DEPTH = 4;

    localparam int SYS_RESET_CYCLES = 16;  // length of reset pulse

    typedef struct packed {
        logic                burst;
        logic [MODE_W-1:0]   mode;
        logic [CHIPID_W-1:0] trg_chipid;
        logic [MODID_W-1:0]  trg_modid;
        logic [CHIPID_W-1:0] src_chipid;
        logic [MODID_W-1:0]  src_modid;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data0;
        logic [DATA_W-1:0]   data1;
    } flit_t;

    // flit plus the ip it came from
    typedef struct packed {
        flit_t       flit;
        logic [31:0] src_ip;
    } ingress_item_t;

    localparam logic [MODE_W-1:0]  MODE_WRITE_POSTED = 4'h1;
    localparam logic [MODID_W-1:0] HOME_MODID        = '0;
    localparam logic [MODID_W-1:0] MODID_ETH         = 8'h3f;  // self test source

    localparam logic [ADDR_W-1:0] RESET_ADDR         = 32'hf0003028;
    localparam logic [ADDR_W-1:0] HOST_IP_MAGIC_ADDR = 32'hdeadbee0;
    localparam logic [DATA_W-1:0] HOST_IP_MAGIC_DATA = 64'hffdebc9a78563412;

    // apb register map
    localparam logic [APB_ADDR_W-1:0] REG_HOST_IP     = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_HOST_PORT   = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_FPGA_PORT   = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_HOST_CHIPID = 8'h0c;
    localparam logic [APB_ADDR_W-1:0] REG_SYS_RESET   = 8'h10;  // write only
    localparam logic [APB_ADDR_W-1:0] REG_STATUS      = 8'h14;  // read only

    localparam logic [31:0] HOST_IP_RESET = {8'd192, 8'd168, 8'd42, 8'd25};
    localparam logic [15:0] HOST_PORT_RESET = 16'd1800;
    localparam logic [15:0] FPGA_PORT_RESET = 16'd1800;
    localparam logic [CHIPID_W-1:0] HOST_CHIPID_RESET = '0;

endpackage

`default_nettype wire
